/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipeCtrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  localparam int FlagW    = 4;   // N, Z, C, V
  localparam int ShiftOpW = 3;   // Instruction bits 6:4

  // Data-processing opcodes in ARM encoding order
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb,
    opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn,
    opOrr, opMov, opBic, opMvn
  } aluOpE;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl
  } condCodeE;

  // Straight from instruction bits 27:26
  typedef enum logic [1:0] {
    clsDataProc = 2'b00,
    clsMem      = 2'b01,
    clsBranch   = 2'b10,
    clsUnimpl   = 2'b11
  } instrClassE;

  // Which datapath unit produces the execute result
  typedef enum logic [1:0] {
    resAlu      = 2'b00,  // Immediate operand or unshifted register
    resShiftImm = 2'b01,
    resShiftReg = 2'b10,
    resMul      = 2'b11
  } resultKindE;

endpackage

`default_nettype wire

/* build.f */
armCtrlPkg.sv
ctrlStageIf.sv
instrDecoder.sv
condUnit.sv
executeCtrl.sv
retireCtrl.sv
pipeCtrl.sv
tb_pipeCtrl.sv

/* condUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module condUnit #(
  parameter logic [armCtrlPkg::FlagW-1:0] FLAG_RESET = '0
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  armCtrlPkg::condCodeE          cond,
  input  logic [1:0]                    flagWrite,
  input  logic                          advance,
  input  logic [armCtrlPkg::FlagW-1:0]  aluFlags,
  output logic                          condEx,
  output logic [armCtrlPkg::FlagW-1:0]  flags
);
  import armCtrlPkg::*;

  logic n, z, c, v;

  assign {n, z, c, v} = flags;

  always_comb begin
    case (cond)
      condEq:  condEx = z;
      condNe:  condEx = ~z;
      condCs:  condEx = c;
      condCc:  condEx = ~c;
      condMi:  condEx = n;
      condPl:  condEx = ~n;
      condVs:  condEx = v;
      condVc:  condEx = ~v;
      condHi:  condEx = c & ~z;
      condLs:  condEx = ~c | z;
      condGe:  condEx = (n == v);
      condLt:  condEx = (n != v);
      condGt:  condEx = ~z & (n == v);
      condLe:  condEx = z | (n != v);
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;   // 4'b1111 not supported
    endcase
  end

  // NZ and CV halves update separately
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= FLAG_RESET;
    end else if (advance && condEx) begin
      if (flagWrite[1]) flags[3:2] <= aluFlags[3:2];
      if (flagWrite[0]) flags[1:0] <= aluFlags[1:0];
    end
  end

endmodule

`default_nettype wire

/* ctrlCases.txt */
// instr aluFlags(10 = random) stallE stallM flushE flushW, then expected: regSrcD immSrcD
// pcWrPendingF aluSrcE aluControlE resultKindE shiftOpE carryInE branchTakenE memtoRegE
// memWriteM regWriteM memtoRegM regWriteW memtoRegW pcSrcW
E2821005 10 0 0 0 0  0 0 0 0 0 0 0 2 0 0  0 0 0  0 0 0  // ADD imm, E still reset
E5843008 10 0 0 0 0  2 1 0 1 4 0 0 2 0 0  0 0 0  0 0 0  // STR
E596500C 10 0 0 0 0  0 1 0 1 4 0 0 2 0 0  0 1 0  0 0 0  // LDR
EA000004 10 0 0 0 0  1 2 1 1 4 0 0 2 0 1  1 0 0  1 0 0  // B
E1A0F001 10 0 0 0 0  0 0 1 1 4 0 0 2 1 0  0 1 1  0 0 0  // MOV pc, r1
E0821123 10 0 0 0 0  0 0 1 0 D 1 0 2 0 0  0 0 0  1 1 0  // ADD LSR #2
E1821453 10 0 0 0 0  0 0 1 0 4 1 2 2 0 0  0 1 0  0 0 1  // ORR ASR r4
E0010392 10 0 0 0 0  0 0 0 0 C 2 5 2 0 0  0 1 0  1 0 1  // MUL
E3510000 10 0 0 0 0  0 0 0 0 0 3 1 2 0 0  0 1 0  1 0 0  // CMPS
0A000002 05 0 0 0 0  1 2 1 1 A 0 0 2 0 0  0 1 0  1 0 0  // BEQ, CMP writes Z and V
1A000002 10 0 0 0 0  1 2 1 1 4 0 0 1 1 0  0 0 0  1 0 0  // BNE, BEQ taken
12821005 10 0 0 0 0  0 0 1 1 4 0 0 1 0 0  0 0 0  0 0 0  // ADDNE, BNE not taken
E3110001 10 0 0 0 0  0 0 0 1 4 0 0 1 0 0  0 0 0  0 0 1  // TSTS, ADDNE fails
E3310001 0A 0 0 0 0  0 0 0 1 8 0 0 1 0 0  0 0 0  0 0 0  // TEQS
E3710001 07 0 0 0 0  0 0 0 1 9 0 0 2 0 0  0 0 0  0 0 0  // CMNS
0A000002 04 0 0 0 0  1 2 1 1 B 0 0 3 0 0  0 0 0  0 0 0  // BEQ
E2821005 10 0 0 0 0  0 0 1 1 4 0 0 0 1 0  0 0 0  0 0 0  // ADD, BEQ taken
E5843008 10 1 0 0 0  2 1 1 1 4 0 0 0 0 0  0 0 0  0 0 0  // STR with stallE
E5843008 10 0 0 0 1  2 1 0 1 4 0 0 0 0 0  0 1 0  0 0 1  // STR again, flushW
E596500C 10 0 0 1 0  0 1 0 1 4 0 0 0 0 0  0 1 0  0 0 0  // LDR flushed
E1821453 10 0 0 0 0  0 0 0 1 4 0 0 0 0 0  1 0 0  1 0 0  // ORR
EC000000 10 0 0 0 0  0 0 0 0 C 2 5 0 0 0  0 0 0  0 0 0  // Unimplemented class

/* ctrlStageIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrlStageIf;
  import armCtrlPkg::*;

  logic                regWrite;
  logic                memWrite;
  logic                memtoReg;
  logic                branch;
  logic                pcSrc;
  logic [1:0]          flagWrite;   // {NZ, CV}
  logic                aluSrc;
  aluOpE               aluControl;
  condCodeE            cond;
  resultKindE          resultKind;
  logic [ShiftOpW-1:0] shiftOp;

  // Decode side
  modport dec (
    output regWrite, memWrite, memtoReg, branch, pcSrc, flagWrite,
           aluSrc, aluControl, cond, resultKind, shiftOp
  );

  // Execute side
  modport exe (
    input regWrite, memWrite, memtoReg, branch, pcSrc, flagWrite,
          aluSrc, aluControl, cond, resultKind, shiftOp
  );

endinterface

`default_nettype wire

/* executeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module executeCtrl #(
  parameter logic [armCtrlPkg::FlagW-1:0] FLAG_RESET = '0
) (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             stallE,
  input  logic                             flushE,
  input  logic [armCtrlPkg::FlagW-1:0]     aluFlagsE,
  ctrlStageIf.exe                          ctrl,
  output logic                             aluSrcE,
  output armCtrlPkg::aluOpE                aluControlE,
  output armCtrlPkg::resultKindE           resultKindE,
  output logic [armCtrlPkg::ShiftOpW-1:0]  shiftOpE,
  output logic [1:0]                       carryInE,
  output logic                             branchTakenE,
  output logic                             memtoRegE,
  output logic                             regWriteGE,
  output logic                             memWriteGE,
  output logic                             pcSrcGE
);
  import armCtrlPkg::*;

  logic             regWriteE, memWriteE, branchE, pcSrcE;
  logic [1:0]       flagWriteE;
  condCodeE         condE;
  logic             condExE;
  logic [FlagW-1:0] flagsE;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      branchE     <= 1'b0;
      pcSrcE      <= 1'b0;
      flagWriteE  <= 2'b00;
      resultKindE <= resAlu;
      aluSrcE     <= 1'b0;
      aluControlE <= opAnd;
      condE       <= condEq;
      shiftOpE    <= '0;
    end else begin
      if (flushE) begin   // Bubble wins over stall
        regWriteE   <= 1'b0;
        memWriteE   <= 1'b0;
        memtoRegE   <= 1'b0;
        branchE     <= 1'b0;
        pcSrcE      <= 1'b0;
        flagWriteE  <= 2'b00;
        resultKindE <= resAlu;
      end else if (!stallE) begin
        regWriteE   <= ctrl.regWrite;
        memWriteE   <= ctrl.memWrite;
        memtoRegE   <= ctrl.memtoReg;
        branchE     <= ctrl.branch;
        pcSrcE      <= ctrl.pcSrc;
        flagWriteE  <= ctrl.flagWrite;
        resultKindE <= ctrl.resultKind;
      end
      if (!stallE) begin   // Side-effect free fields
        aluSrcE     <= ctrl.aluSrc;
        aluControlE <= ctrl.aluControl;
        condE       <= ctrl.cond;
        shiftOpE    <= ctrl.shiftOp;
      end
    end
  end

  condUnit #(.FLAG_RESET(FLAG_RESET)) condUnit_i (
    .clk       (clk),
    .rstN      (rstN),
    .cond      (condE),
    .flagWrite (flagWriteE),
    .advance   (~stallE),
    .aluFlags  (aluFlagsE),
    .condEx    (condExE),
    .flags     (flagsE)
  );

  // Only a passing condition lets side effects through
  assign branchTakenE = branchE & condExE;
  assign regWriteGE   = regWriteE & condExE;
  assign memWriteGE   = memWriteE & condExE;
  assign pcSrcGE      = pcSrcE & condExE;
  assign carryInE     = flagsE[1:0];   // C and V for ADC, SBC, RSC

  flushKillsWrites: assert property (@(posedge clk) disable iff (!rstN)
    flushE |=> !(regWriteGE || memWriteGE || pcSrcGE || branchTakenE));

endmodule

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic [31:4] instrD,
  ctrlStageIf.dec     ctrl,
  output logic [1:0]  regSrcD,
  output logic [1:0]  immSrcD,
  output logic        pcSrcD
);
  import armCtrlPkg::*;

  instrClassE instrClass;
  logic       isMul;
  logic       isCompare;
  logic       sBit;

  assign instrClass = instrClassE'(instrD[27:26]);
  assign isMul      = ~instrD[25] & instrD[7] & instrD[4];      // Register form only
  assign isCompare  = (instrD[24:23] == 2'b10) & ~isMul;        // TST, TEQ, CMP, CMN
  assign sBit       = instrD[20];

  always_comb begin
    regSrcD         = 2'b00;
    immSrcD         = 2'b00;
    ctrl.aluSrc     = 1'b0;
    ctrl.regWrite   = 1'b0;
    ctrl.memWrite   = 1'b0;
    ctrl.memtoReg   = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.aluControl = opAdd;   // Address and branch target adds
    ctrl.flagWrite  = 2'b00;
    ctrl.resultKind = resAlu;
    case (instrClass)
      clsDataProc: begin
        ctrl.aluSrc     = instrD[25];
        ctrl.regWrite   = ~isCompare;
        ctrl.aluControl = aluOpE'(instrD[24:21]);
        ctrl.flagWrite  = {sBit, sBit};
        if (isMul)
          ctrl.resultKind = resMul;
        else if (!instrD[25])
          ctrl.resultKind = instrD[4] ? resShiftReg : resShiftImm;
      end
      clsMem: begin
        immSrcD       = 2'b01;
        ctrl.aluSrc   = 1'b1;
        if (instrD[20]) begin   // LDR
          ctrl.regWrite = 1'b1;
          ctrl.memtoReg = 1'b1;
        end else begin          // STR reads Rd as data
          regSrcD       = 2'b10;
          ctrl.memWrite = 1'b1;
        end
      end
      clsBranch: begin
        regSrcD     = 2'b01;   // Base is the PC
        immSrcD     = 2'b10;
        ctrl.aluSrc = 1'b1;
        ctrl.branch = 1'b1;
      end
      default: ;   // Unimplemented leaves everything inactive
    endcase
  end

  // Write to r15 redirects fetch just like a branch
  assign pcSrcD = ((instrD[15:12] == 4'hF) & ctrl.regWrite) | ctrl.branch;

  assign ctrl.pcSrc   = pcSrcD;
  assign ctrl.cond    = condCodeE'(instrD[31:28]);
  assign ctrl.shiftOp = instrD[6:4];

  always_comb begin
    if (instrD[27:26] == 2'b11)
      unimplNoWrite: assert final (!ctrl.regWrite && !ctrl.memWrite && !pcSrcD);
  end

endmodule

`default_nettype wire

/* pipeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl #(
  parameter logic [armCtrlPkg::FlagW-1:0] FLAG_RESET = '0
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [31:4]                     instrD,
  input  logic [armCtrlPkg::FlagW-1:0]    aluFlagsE,
  input  logic                            stallE,
  input  logic                            stallM,
  input  logic                            flushE,
  input  logic                            flushW,
  output logic [1:0]                      regSrcD,
  output logic [1:0]                      immSrcD,
  output logic                            aluSrcE,
  output logic [3:0]                      aluControlE,
  output logic [1:0]                      resultKindE,
  output logic [armCtrlPkg::ShiftOpW-1:0] shiftOpE,
  output logic [1:0]                      carryInE,
  output logic                            branchTakenE,
  output logic                            memtoRegE,
  output logic                            memWriteM,
  output logic                            memtoRegM,
  output logic                            regWriteM,
  output logic                            memtoRegW,
  output logic                            regWriteW,
  output logic                            pcSrcW,
  output logic                            pcWrPendingF
);

  logic pcSrcD;
  logic regWriteGE, memWriteGE, pcSrcGE;   // Condition-gated execute writes

  ctrlStageIf ctrlDE ();

  instrDecoder instrDecoder_i (
    .instrD  (instrD),
    .ctrl    (ctrlDE),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .pcSrcD  (pcSrcD)
  );

  executeCtrl #(.FLAG_RESET(FLAG_RESET)) executeCtrl_i (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .aluFlagsE    (aluFlagsE),
    .ctrl         (ctrlDE),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .resultKindE  (resultKindE),
    .shiftOpE     (shiftOpE),
    .carryInE     (carryInE),
    .branchTakenE (branchTakenE),
    .memtoRegE    (memtoRegE),
    .regWriteGE   (regWriteGE),
    .memWriteGE   (memWriteGE),
    .pcSrcGE      (pcSrcGE)
  );

  retireCtrl retireCtrl_i (
    .clk          (clk),
    .rstN         (rstN),
    .stallM       (stallM),
    .flushW       (flushW),
    .memWriteGE   (memWriteGE),
    .memtoRegE    (memtoRegE),
    .regWriteGE   (regWriteGE),
    .pcSrcGE      (pcSrcGE),
    .pcSrcD       (pcSrcD),
    .memWriteM    (memWriteM),
    .memtoRegM    (memtoRegM),
    .regWriteM    (regWriteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF)
  );

endmodule

`default_nettype wire

/* retireCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module retireCtrl (
  input  logic clk,
  input  logic rstN,
  input  logic stallM,
  input  logic flushW,
  input  logic memWriteGE,
  input  logic memtoRegE,
  input  logic regWriteGE,
  input  logic pcSrcGE,
  input  logic pcSrcD,
  output logic memWriteM,
  output logic memtoRegM,
  output logic regWriteM,
  output logic memtoRegW,
  output logic regWriteW,
  output logic pcSrcW,
  output logic pcWrPendingF
);

  logic pcSrcM;

  // Memory stage
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
    end else if (!stallM) begin
      memWriteM <= memWriteGE;
      memtoRegM <= memtoRegE;
      regWriteM <= regWriteGE;
      pcSrcM    <= pcSrcGE;
    end
  end

  // Writeback stage has a flush but no stall
  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      memtoRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else begin
      memtoRegW <= memtoRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  // Fetch must wait while any older PC write is in flight
  assign pcWrPendingF = pcSrcD | pcSrcGE | pcSrcM;

  // A PC write leaving execute still holds fetch from the memory stage
  pendingCoversMem: assert property (@(posedge clk) disable iff (!rstN)
    pcSrcGE && !stallM |=> pcWrPendingF);

endmodule

`default_nettype wire

/* tb_pipeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipeCtrl;

  localparam int          ClkPeriod   = 8;
  localparam int          ResetCycles = 5;
  localparam int          NumFields   = 22;   // 6 stimulus + 16 expected
  localparam int          MaxRows     = 64;
  localparam int          RandSeed    = 34490;
  localparam logic [3:0]  FlagReset   = 4'b0010;   // Only C set
  localparam logic [31:0] EndMark     = 32'hDEAD_BEEF;
  localparam logic [31:0] AnyFlags    = 32'h10;    // Flags not written this cycle

  logic        clk;
  logic        rstN;
  logic [31:4] instrD;
  logic [3:0]  aluFlagsE;
  logic        stallE, stallM, flushE, flushW;

  logic [1:0] regSrcD, immSrcD;
  logic       aluSrcE;
  logic [3:0] aluControlE;
  logic [1:0] resultKindE;
  logic [2:0] shiftOpE;
  logic [1:0] carryInE;
  logic       branchTakenE, memtoRegE;
  logic       memWriteM, memtoRegM, regWriteM;
  logic       memtoRegW, regWriteW, pcSrcW, pcWrPendingF;

  logic [31:0] caseMem [0:MaxRows*NumFields-1];
  int          rowCount;
  int          errorCount;
  int          curRow;
  logic        casesLoaded;

  pipeCtrl #(.FLAG_RESET(FlagReset)) dut_i (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .stallE       (stallE),
    .stallM       (stallM),
    .flushE       (flushE),
    .flushW       (flushW),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .resultKindE  (resultKindE),
    .shiftOpE     (shiftOpE),
    .carryInE     (carryInE),
    .branchTakenE (branchTakenE),
    .memtoRegE    (memtoRegE),
    .memWriteM    (memWriteM),
    .memtoRegM    (memtoRegM),
    .regWriteM    (regWriteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic checkVal(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    if (actVal !== expVal) begin
      errorCount++;
      $display("[FAIL] time %0d ns row %0d: %s expected %0h, got %0h",
               $time, curRow, name, expVal, actVal);
    end
  endtask

  // Nothing may write while the pipeline sits in reset
  task automatic checkResetState();
    checkVal("regWriteM",    32'h0, 32'(regWriteM));
    checkVal("memWriteM",    32'h0, 32'(memWriteM));
    checkVal("memtoRegM",    32'h0, 32'(memtoRegM));
    checkVal("regWriteW",    32'h0, 32'(regWriteW));
    checkVal("memtoRegW",    32'h0, 32'(memtoRegW));
    checkVal("pcSrcW",       32'h0, 32'(pcSrcW));
    checkVal("memtoRegE",    32'h0, 32'(memtoRegE));
    checkVal("branchTakenE", 32'h0, 32'(branchTakenE));
    checkVal("pcWrPendingF", 32'h0, 32'(pcWrPendingF));
    checkVal("carryInE",     32'(FlagReset[1:0]), 32'(carryInE));
  endtask

  task automatic applyRow(input int row);
    int          b;
    logic [31:0] randVal;
    b = row * NumFields;
    instrD <= caseMem[b][31:4];
    if (caseMem[b + 1] == AnyFlags) begin
      randVal = $urandom();
      aluFlagsE <= randVal[3:0];
    end else begin
      aluFlagsE <= caseMem[b + 1][3:0];
    end
    stallE <= caseMem[b + 2][0];
    stallM <= caseMem[b + 3][0];
    flushE <= caseMem[b + 4][0];
    flushW <= caseMem[b + 5][0];
  endtask

  task automatic checkRow(input int row);
    int b;
    b = row * NumFields + 6;   // First expected column
    checkVal("regSrcD",      caseMem[b],      32'(regSrcD));
    checkVal("immSrcD",      caseMem[b + 1],  32'(immSrcD));
    checkVal("pcWrPendingF", caseMem[b + 2],  32'(pcWrPendingF));
    checkVal("aluSrcE",      caseMem[b + 3],  32'(aluSrcE));
    checkVal("aluControlE",  caseMem[b + 4],  32'(aluControlE));
    checkVal("resultKindE",  caseMem[b + 5],  32'(resultKindE));
    checkVal("shiftOpE",     caseMem[b + 6],  32'(shiftOpE));
    checkVal("carryInE",     caseMem[b + 7],  32'(carryInE));
    checkVal("branchTakenE", caseMem[b + 8],  32'(branchTakenE));
    checkVal("memtoRegE",    caseMem[b + 9],  32'(memtoRegE));
    checkVal("memWriteM",    caseMem[b + 10], 32'(memWriteM));
    checkVal("regWriteM",    caseMem[b + 11], 32'(regWriteM));
    checkVal("memtoRegM",    caseMem[b + 12], 32'(memtoRegM));
    checkVal("regWriteW",    caseMem[b + 13], 32'(regWriteW));
    checkVal("memtoRegW",    caseMem[b + 14], 32'(memtoRegW));
    checkVal("pcSrcW",       caseMem[b + 15], 32'(pcSrcW));
  endtask

  initial begin
    clk         = 1'b0;
    rstN        = 1'b0;
    instrD      = '0;
    aluFlagsE   = '0;
    stallE      = 1'b0;
    stallM      = 1'b0;
    flushE      = 1'b0;
    flushW      = 1'b0;
    errorCount  = 0;
    rowCount    = 0;
    curRow      = -1;
    casesLoaded = 1'b0;
    void'($urandom(RandSeed));

    for (int i = 0; i < MaxRows * NumFields; i++) caseMem[i] = EndMark;
    $readmemh("ctrlCases.txt", caseMem);
    while (rowCount < MaxRows && caseMem[rowCount * NumFields] != EndMark)
      rowCount++;
    casesLoaded = 1'b1;
    if (rowCount == 0) begin
      errorCount++;
      $display("No stimulus rows could be read from ctrlCases.txt");
    end

    // Registers are unknown until the first reset edge
    for (int i = 1; i < ResetCycles; i++) begin
      @(posedge clk);
      #(ClkPeriod - 1);
      checkResetState();
    end

    for (int row = 0; row < rowCount; row++) begin
      @(posedge clk);
      if (row == 0) rstN <= 1'b1;   // Last reset edge
      curRow = row;
      applyRow(row);
      #(ClkPeriod - 1);   // Just before the next edge
      checkRow(row);
    end

    $display("Done with %0d rows, error count %0d", rowCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (casesLoaded);
    #((rowCount + 10 + ResetCycles) * ClkPeriod);
    $display("Timed out after %0d cycles without reaching the end of the cases",
             rowCount + 10 + ResetCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
